// File: ctrl_pkg.sv
// Shared types and constants for the instruction control unit.
// Every design file refers to these by scoped name, ctrl_pkg::name.
package ctrl_pkg;

    // Sequencer phases in a 5-bit encoding
    typedef enum logic [4:0] {
        FETCH    = 5'd0,
        FILL_IMM = 5'd4,
        ILLEGAL  = 5'd31
    } phase_t;

    // Operations issued to the ALU
    typedef enum logic [5:0] {
        ALU_NOP  = 6'd0,
        ALU_MOVE = 6'd1,
        ALU_RCF  = 6'd2,   // Reset carry
        ALU_SCF  = 6'd3,   // Set carry
        ALU_CCF  = 6'd4,   // Complement carry
        ALU_ZCF  = 6'd5    // Carry from inverted zero
    } alu_op_t;

    // Operand size of the load-immediate group
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_LONG = 2'd2
    } size_t;

    // Bit positions inside the flags byte
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    localparam int REG_CODE_W = 8;   // Full register code
    localparam int WE_W       = 3;   // Byte, word, long write enables
    localparam int IMM_W      = 32;  // ALU immediate

    // Single-byte opcodes
    localparam logic [7:0] OP_NOP  = 8'h00;
    localparam logic [7:0] OP_RCF  = 8'h10;
    localparam logic [7:0] OP_SCF  = 8'h11;
    localparam logic [7:0] OP_CCF  = 8'h12;
    localparam logic [7:0] OP_ZCF  = 8'h13;
    localparam logic [7:0] OP_JP16 = 8'h1A;  // Absolute jump, 16-bit address
    localparam logic [7:0] OP_JP24 = 8'h1B;  // Absolute jump, 24-bit address

    // Opcode groups by upper nibble
    localparam logic [3:0] OP_LDB_HI  = 4'h2;  // LD r,# byte
    localparam logic [3:0] OP_LDW_HI  = 4'h3;  // LD r,# word
    localparam logic [3:0] OP_LDL_HI  = 4'h4;  // LD r,# long
    localparam logic [3:0] OP_JR8_HI  = 4'h6;  // JR cc with 8-bit offset
    localparam logic [3:0] OP_JR16_HI = 4'h7;  // JR cc with 16-bit offset

endpackage

// File: operand_decode.sv
// Operand decoder for the load-immediate group.
// Gives the operand size, the full register code and the matching
// one-hot write mask from the current opcode byte. Purely combinational.
`timescale 1ns/100ps

module operand_decode (
    input  logic [7:0]                      opcode,
    output ctrl_pkg::size_t                 size,
    output logic [ctrl_pkg::REG_CODE_W-1:0] reg_code,
    output logic [ctrl_pkg::WE_W-1:0]       we_mask
);

    logic [2:0] short_reg;  // Three-bit register field

    assign short_reg = opcode[2:0];

    always_comb begin
        case (opcode[7:4])
            ctrl_pkg::OP_LDB_HI: size = ctrl_pkg::SZ_BYTE;
            ctrl_pkg::OP_LDW_HI: size = ctrl_pkg::SZ_WORD;
            ctrl_pkg::OP_LDL_HI: size = ctrl_pkg::SZ_LONG;
            default:             size = ctrl_pkg::SZ_BYTE;  // Unused outside the group
        endcase
    end

    // Byte registers sit in bank E with the low/high byte swapped by ~r[0].
    // Word and long registers pick bank F for r4-r7.
    always_comb begin
        if (size == ctrl_pkg::SZ_BYTE) begin
            reg_code = {4'he, short_reg[2:1], 1'b0, ~short_reg[0]};
        end else if (short_reg[2]) begin
            reg_code = {4'hf, short_reg[1:0], 2'b00};
        end else begin
            reg_code = {4'he, short_reg[1:0], 2'b00};
        end
    end

    always_comb begin
        case (size)
            ctrl_pkg::SZ_BYTE: we_mask = 3'b001;
            ctrl_pkg::SZ_WORD: we_mask = 3'b010;
            default:           we_mask = 3'b100;  // Long
        endcase
    end

endmodule

// File: cond_eval.sv
// Jump condition evaluator.
// Codes 0-7 test a flag combination, codes 8-15 are their negations,
// so bit 3 of the condition simply inverts the result.
`timescale 1ns/100ps

module cond_eval (
    input  logic [3:0] cond,
    input  logic [7:0] flags,
    output logic       taken
);

    logic s_xor_v;  // Signed less
    logic base;     // Result before negation

    assign s_xor_v = flags[ctrl_pkg::FLAG_S] ^ flags[ctrl_pkg::FLAG_V];

    always_comb begin
        case (cond[2:0])
            3'd0:    base = 1'b0;                                          // False
            3'd1:    base = s_xor_v;                                       // Signed <
            3'd2:    base = flags[ctrl_pkg::FLAG_Z] | s_xor_v;             // Signed <=
            3'd3:    base = flags[ctrl_pkg::FLAG_Z] | flags[ctrl_pkg::FLAG_C]; // Unsigned <=
            3'd4:    base = flags[ctrl_pkg::FLAG_V];                       // Overflow
            3'd5:    base = flags[ctrl_pkg::FLAG_S];                       // Minus
            3'd6:    base = flags[ctrl_pkg::FLAG_Z];                       // Equal
            default: base = flags[ctrl_pkg::FLAG_C];                       // Carry
        endcase
    end

    assign taken = base ^ cond[3];  // Code 8 becomes always true

endmodule

// File: ctrl_seq.sv
// Instruction sequencer of the control unit.
// Decodes the opcode window, reports the consumed byte count on fetched and
// registers the control pulses one clock later. Word/long loads and absolute
// jumps gather the rest of their immediate in FILL_IMM. After every consume
// the window is ignored for one cycle to cover the stream latency.
`timescale 1ns/100ps

module ctrl_seq (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [31:0]                     op,
    input  logic                            op_ok,
    input  ctrl_pkg::size_t                 size,
    input  logic [ctrl_pkg::REG_CODE_W-1:0] reg_code,
    input  logic [ctrl_pkg::WE_W-1:0]       we_mask,
    input  logic                            taken,
    output logic [2:0]                      fetched,
    output logic                            pc_we,
    output logic                            pc_rel,
    output logic                            flag_we,
    output logic                            alu_wait,
    output logic                            alu_smux,
    output logic                            illegal,
    output ctrl_pkg::alu_op_t               alu_op,
    output logic [ctrl_pkg::IMM_W-1:0]      alu_imm,
    output logic [ctrl_pkg::REG_CODE_W-1:0] regs_dst,
    output logic [ctrl_pkg::WE_W-1:0]       regs_we
);

    ctrl_pkg::phase_t                phase;
    ctrl_pkg::phase_t                nx_phase;
    logic                            wait_q;       // Latency slot after a consume
    logic [1:0]                      pend_len;     // Immediate bytes still to fetch
    logic [1:0]                      nx_pend_len;
    logic [ctrl_pkg::WE_W-1:0]       pend_we;      // Register write held for FILL_IMM
    logic [ctrl_pkg::WE_W-1:0]       nx_pend_we;
    logic                            pend_pc;      // PC write held for FILL_IMM
    logic                            nx_pend_pc;
    logic                            bad_op;
    logic                            nx_pc_we;
    logic                            nx_pc_rel;
    logic                            nx_flag_we;
    logic                            nx_alu_wait;
    logic                            nx_alu_smux;
    logic                            nx_illegal;
    ctrl_pkg::alu_op_t               nx_alu_op;
    logic [ctrl_pkg::IMM_W-1:0]      nx_alu_imm;
    logic [ctrl_pkg::REG_CODE_W-1:0] nx_regs_dst;
    logic [ctrl_pkg::WE_W-1:0]       nx_regs_we;

    always_comb begin
        fetched     = 3'd0;
        bad_op      = 1'b0;
        nx_phase    = phase;
        nx_pend_len = pend_len;
        nx_pend_we  = pend_we;
        nx_pend_pc  = pend_pc;
        nx_pc_we    = 1'b0;     // Pulses last a single cycle
        nx_pc_rel   = 1'b0;
        nx_flag_we  = 1'b0;
        nx_regs_we  = '0;
        nx_alu_wait = alu_wait;
        nx_alu_smux = alu_smux;
        nx_alu_op   = alu_op;
        nx_alu_imm  = alu_imm;
        nx_regs_dst = regs_dst;
        nx_illegal  = illegal;
        if (op_ok && !wait_q) begin
            case (phase)
                ctrl_pkg::FETCH: begin
                    nx_alu_op   = ctrl_pkg::ALU_NOP;
                    nx_alu_smux = 1'b0;
                    nx_alu_wait = 1'b0;
                    case (op[7:0])
                        ctrl_pkg::OP_NOP: begin
                            fetched = 3'd1;
                        end
                        ctrl_pkg::OP_RCF,
                        ctrl_pkg::OP_SCF,
                        ctrl_pkg::OP_CCF,
                        ctrl_pkg::OP_ZCF: begin
                            fetched    = 3'd1;
                            nx_flag_we = 1'b1;
                            case (op[1:0])
                                2'd0:    nx_alu_op = ctrl_pkg::ALU_RCF;
                                2'd1:    nx_alu_op = ctrl_pkg::ALU_SCF;
                                2'd2:    nx_alu_op = ctrl_pkg::ALU_CCF;
                                default: nx_alu_op = ctrl_pkg::ALU_ZCF;
                            endcase
                        end
                        ctrl_pkg::OP_JP16,
                        ctrl_pkg::OP_JP24: begin
                            fetched     = 3'd2;
                            nx_alu_imm  = {24'd0, op[15:8]};  // Address low byte
                            nx_alu_wait = 1'b1;
                            nx_pend_len = (op[7:0] == ctrl_pkg::OP_JP24) ? 2'd2 : 2'd1;
                            nx_pend_we  = '0;
                            nx_pend_pc  = 1'b1;
                            nx_phase    = ctrl_pkg::FILL_IMM;
                        end
                        default: begin
                            case (op[7:4])
                                ctrl_pkg::OP_LDB_HI,
                                ctrl_pkg::OP_LDW_HI,
                                ctrl_pkg::OP_LDL_HI: begin
                                    if (op[3]) begin
                                        bad_op = 1'b1;  // 0x_8-0x_F not defined
                                    end else begin
                                        fetched     = 3'd2;
                                        nx_alu_op   = ctrl_pkg::ALU_MOVE;
                                        nx_alu_smux = 1'b1;
                                        nx_regs_dst = reg_code;
                                        nx_alu_imm  = {24'd0, op[15:8]};
                                        if (size == ctrl_pkg::SZ_BYTE) begin
                                            nx_regs_we = we_mask;
                                        end else begin
                                            nx_alu_wait = 1'b1;
                                            nx_pend_we  = we_mask;
                                            nx_pend_pc  = 1'b0;
                                            nx_pend_len = (size == ctrl_pkg::SZ_WORD) ?
                                                          2'd1 : 2'd3;
                                            nx_phase    = ctrl_pkg::FILL_IMM;
                                        end
                                    end
                                end
                                ctrl_pkg::OP_JR8_HI: begin
                                    fetched    = 3'd2;
                                    nx_alu_imm = {{24{op[15]}}, op[15:8]} + 32'd2;
                                    nx_pc_rel  = taken;
                                end
                                ctrl_pkg::OP_JR16_HI: begin
                                    fetched    = 3'd3;
                                    nx_alu_imm = {{16{op[23]}}, op[23:8]} + 32'd3;
                                    nx_pc_rel  = taken;
                                end
                                default: begin
                                    bad_op = 1'b1;
                                end
                            endcase
                        end
                    endcase
                end
                ctrl_pkg::FILL_IMM: begin
                    fetched     = {1'b0, pend_len};
                    nx_regs_we  = pend_we;
                    nx_pc_we    = pend_pc;
                    nx_alu_wait = 1'b0;
                    nx_phase    = ctrl_pkg::FETCH;
                    case (pend_len)
                        2'd1:    nx_alu_imm = {16'd0, op[7:0], alu_imm[7:0]};
                        2'd2:    nx_alu_imm = {8'd0, op[15:0], alu_imm[7:0]};
                        default: nx_alu_imm = {op[23:0], alu_imm[7:0]};  // Long load
                    endcase
                end
                default: ;  // ILLEGAL holds until reset
            endcase
        end
        if (bad_op) begin
            nx_phase   = ctrl_pkg::ILLEGAL;
            nx_illegal = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= ctrl_pkg::FETCH;
            wait_q   <= 1'b0;
            pend_len <= 2'd0;
            pend_we  <= '0;
            pend_pc  <= 1'b0;
            pc_we    <= 1'b0;
            pc_rel   <= 1'b0;
            flag_we  <= 1'b0;
            alu_wait <= 1'b0;
            alu_smux <= 1'b0;
            illegal  <= 1'b0;
            alu_op   <= ctrl_pkg::ALU_NOP;
            alu_imm  <= '0;
            regs_dst <= '0;
            regs_we  <= '0;
        end else begin
            phase    <= nx_phase;
            wait_q   <= (fetched != 3'd0);
            pend_len <= nx_pend_len;
            pend_we  <= nx_pend_we;
            pend_pc  <= nx_pend_pc;
            pc_we    <= nx_pc_we;
            pc_rel   <= nx_pc_rel;
            flag_we  <= nx_flag_we;
            alu_wait <= nx_alu_wait;
            alu_smux <= nx_alu_smux;
            illegal  <= nx_illegal;
            alu_op   <= nx_alu_op;
            alu_imm  <= nx_alu_imm;
            regs_dst <= nx_regs_dst;
            regs_we  <= nx_regs_we;
        end
    end

endmodule

// File: tlcs_ctrl.sv
// Top level of the instruction control unit.
// The operand decoder and the condition evaluator both look at the current
// opcode byte and the sequencer combines their results into control pulses.
`timescale 1ns/100ps

module tlcs_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [31:0]                     op,        // Little-endian opcode window
    input  logic                            op_ok,
    input  logic [7:0]                      flags,
    output logic [2:0]                      fetched,   // Bytes consumed this cycle
    output logic                            pc_we,
    output logic                            pc_rel,
    output logic                            flag_we,
    output logic                            alu_wait,
    output logic                            alu_smux,
    output logic                            illegal,
    output ctrl_pkg::alu_op_t               alu_op,
    output logic [ctrl_pkg::IMM_W-1:0]      alu_imm,
    output logic [ctrl_pkg::REG_CODE_W-1:0] regs_dst,
    output logic [ctrl_pkg::WE_W-1:0]       regs_we
);

    ctrl_pkg::size_t                 size;
    logic [ctrl_pkg::REG_CODE_W-1:0] reg_code;
    logic [ctrl_pkg::WE_W-1:0]       we_mask;
    logic                            taken;

    operand_decode dec0 (
        .opcode   (op[7:0]),
        .size     (size),
        .reg_code (reg_code),
        .we_mask  (we_mask)
    );

    cond_eval cond0 (
        .cond  (op[3:0]),   // Condition field of JR
        .flags (flags),
        .taken (taken)
    );

    ctrl_seq seq0 (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .op_ok    (op_ok),
        .size     (size),
        .reg_code (reg_code),
        .we_mask  (we_mask),
        .taken    (taken),
        .fetched  (fetched),
        .pc_we    (pc_we),
        .pc_rel   (pc_rel),
        .flag_we  (flag_we),
        .alu_wait (alu_wait),
        .alu_smux (alu_smux),
        .illegal  (illegal),
        .alu_op   (alu_op),
        .alu_imm  (alu_imm),
        .regs_dst (regs_dst),
        .regs_we  (regs_we)
    );

endmodule

// File: tlcs_ctrl_model.svh
// Reference model of the control unit, included by the testbench.
// Decodes the instruction at model_ptr from the program bytes and queues
// the expected fetched counts and the expected control pulse.

typedef struct packed {
    logic [2:0]  kind;      // {flag_we, pc_we, pc_rel}
    logic [2:0]  we;
    logic [5:0]  op;
    logic [31:0] imm;
    logic [7:0]  dst;
    logic        chk_imm;
    logic        chk_dst;
} event_t;

event_t ev_q[$];
string  name_q[$];
int     fetch_q[$];         // Nonzero fetched values still to come
int     model_ptr;

function automatic logic cond_holds(input logic [3:0] cc, input logic [7:0] fl);
    logic lt;
    logic res;
    lt = fl[ctrl_pkg::FLAG_S] ^ fl[ctrl_pkg::FLAG_V];  // Signed less
    case (cc[2:0])
        3'd0:    res = 1'b0;
        3'd1:    res = lt;
        3'd2:    res = lt | fl[ctrl_pkg::FLAG_Z];
        3'd3:    res = fl[ctrl_pkg::FLAG_C] | fl[ctrl_pkg::FLAG_Z];  // Unsigned <=
        3'd4:    res = fl[ctrl_pkg::FLAG_V];
        3'd5:    res = fl[ctrl_pkg::FLAG_S];
        3'd6:    res = fl[ctrl_pkg::FLAG_Z];
        default: res = fl[ctrl_pkg::FLAG_C];
    endcase
    return res ^ cc[3];     // Codes 8-15 negate 0-7
endfunction

task automatic model_decode(input logic [7:0] fl);
    logic [7:0]  opc;
    logic [31:0] val;
    int          nb;
    int          i;
    event_t      ev;
    opc   = prog[model_ptr];
    ev    = '0;
    ev.op = ctrl_pkg::ALU_NOP;
    nb    = 0;
    if (opc[7:2] == 6'b000100) begin
        ev.kind = 3'b100;
        case (opc[1:0])
            2'd0:    ev.op = ctrl_pkg::ALU_RCF;
            2'd1:    ev.op = ctrl_pkg::ALU_SCF;
            2'd2:    ev.op = ctrl_pkg::ALU_CCF;
            default: ev.op = ctrl_pkg::ALU_ZCF;
        endcase
    end else if (opc[7:4] inside {4'h2, 4'h3, 4'h4} && !opc[3]) begin
        nb         = (opc[7:4] == 4'h4) ? 4 : opc[7:4] - 1;  // 1, 2 or 4 immediate bytes
        ev.we      = 3'(1 << (opc[7:4] - 2));
        ev.op      = ctrl_pkg::ALU_MOVE;
        ev.dst     = (nb == 1) ? {4'he, opc[2:1], 1'b0, ~opc[0]}
                               : {opc[2] ? 4'hf : 4'he, opc[1:0], 2'b00};
        ev.chk_dst = 1'b1;
    end else if (opc == 8'h1a || opc == 8'h1b) begin
        nb      = opc[0] ? 3 : 2;   // 16- or 24-bit address
        ev.kind = 3'b010;
    end else if (opc[7:5] == 3'b011) begin
        nb = opc[4] ? 2 : 1;        // Relative offset bytes
    end else if (opc != 8'h00) begin
        stop_run($sformatf("model met opcode 0x%02h outside the program set", opc));
    end
    val = '0;
    for (i = nb; i > 0; i--) begin
        val = {val[23:0], prog[model_ptr + i]};
    end
    ev.imm     = val;
    ev.chk_imm = (nb != 0);
    if (opc[7:5] == 3'b011) begin
        val     = (nb == 1) ? {{24{val[7]}}, val[7:0]} : {{16{val[15]}}, val[15:0]};
        ev.imm  = val + nb + 1;     // Offset counts from the next instruction
        ev.kind = cond_holds(opc[3:0], fl) ? 3'b001 : 3'b000;
        fetch_q.push_back(nb + 1);
    end else if (nb >= 2) begin
        fetch_q.push_back(2);
        fetch_q.push_back(nb - 1);  // Rest of the immediate
    end else begin
        fetch_q.push_back(nb + 1);
    end
    if (ev.kind != 0 || ev.we != 0) begin
        ev_q.push_back(ev);
        name_q.push_back($sformatf("op 0x%02h at %0d", opc, model_ptr));
    end
    model_ptr += nb + 1;
endtask

// File: tlcs_ctrl_tb.sv
// Testbench for the instruction control unit.
// Streams a random program through the DUT and checks each consume count,
// each control pulse and the final illegal stop against the model.
`timescale 1ns/100ps

module tlcs_ctrl_tb;

    localparam int N_INSTR  = 300;
    localparam int MEM_SIZE = 2048;
    localparam int LIMIT    = N_INSTR * 12 + 100;     // Cycle budget
    localparam int NB_OF [9] = '{0, 0, 1, 2, 4, 2, 3, 1, 2};  // Immediate bytes per kind

    logic              clk = 1'b0;
    logic              rst;
    logic [31:0]       op;
    logic              op_ok;
    logic [7:0]        flags;
    logic [2:0]        fetched;
    logic              pc_we;
    logic              pc_rel;
    logic              flag_we;
    logic              alu_wait;
    logic              alu_smux;
    logic              illegal;
    ctrl_pkg::alu_op_t alu_op;
    logic [31:0]       alu_imm;
    logic [7:0]        regs_dst;
    logic [2:0]        regs_we;

    logic [7:0] prog [MEM_SIZE];
    int         end_pos;                  // Address of the closing 0xFF

    tlcs_ctrl dut0 (.*);

    always #4 clk = ~clk;  // 8 ns period

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic mismatch(input string test, input string field,
                            input logic [31:0] exp, input logic [31:0] act);
        stop_run($sformatf("MISMATCH %s %s expected 0x%08h actual 0x%08h",
                           test, field, exp, act));
    endtask

    `include "tlcs_ctrl_model.svh"

    task automatic build_program();
        int         a;
        int         p;
        int         kind;
        logic [7:0] opc;
        for (a = 0; a < MEM_SIZE; a++) begin
            prog[a] = a[7:0] ^ {5'd0, a[10:8]};
        end
        p = 0;
        repeat (N_INSTR) begin
            kind = $urandom % 9;
            case (kind)
                0:       opc = 8'h00;
                1:       opc = 8'h10 | 8'($urandom % 4);         // Flag ops
                2, 3, 4: opc = {4'(kind), 1'b0, 3'($urandom)};   // Loads
                5:       opc = 8'h1a;
                6:       opc = 8'h1b;
                7:       opc = {4'h6, 4'($urandom)};
                default: opc = {4'h7, 4'($urandom)};
            endcase
            prog[p] = opc;
            repeat (NB_OF[kind]) begin
                p++;
                prog[p] = 8'($urandom);
            end
            p++;
        end
        prog[p] = 8'hff;
        end_pos = p;
    endtask

    function automatic logic [31:0] window(input int p);
        return {prog[p + 3], prog[p + 2], prog[p + 1], prog[p]};
    endfunction

    task automatic check_idle();
        assert (!pc_we && !pc_rel && !flag_we && !alu_wait && !alu_smux && !illegal &&
                alu_op == ctrl_pkg::ALU_NOP && alu_imm == 0 && regs_dst == 0 &&
                regs_we == 0 && fetched == 0)
            else stop_run("control outputs not cleared around reset");
    endtask

    task automatic check_pulse();
        event_t ev;
        string  name;
        if (flag_we || pc_we || pc_rel || regs_we != 0) begin
            assert (ev_q.size() != 0) else stop_run("control pulse with no instruction pending");
            ev   = ev_q.pop_front();
            name = name_q.pop_front();
            assert ({flag_we, pc_we, pc_rel} == ev.kind)
                else mismatch(name, "pulse", ev.kind, {flag_we, pc_we, pc_rel});
            assert (regs_we == ev.we) else mismatch(name, "regs_we", ev.we, regs_we);
            assert (alu_op == ev.op) else mismatch(name, "alu_op", ev.op, alu_op);
            assert (!ev.chk_imm || alu_imm == ev.imm)
                else mismatch(name, "alu_imm", ev.imm, alu_imm);
            assert (!ev.chk_dst || regs_dst == ev.dst)
                else mismatch(name, "regs_dst", ev.dst, regs_dst);
            assert (!ev.chk_dst || alu_smux) else mismatch(name, "alu_smux", 1, alu_smux);
        end
    endtask

    initial begin
        int   ptr;
        int   cycles;
        int   ill_cycles;
        int   want;
        logic last_fetch;
        rst   = 1'b1;
        op    = '0;
        op_ok = 1'b0;
        flags = '0;
        void'($urandom(32'hfb18));
        build_program();
        model_ptr  = 0;
        ptr        = 0;
        cycles     = 0;
        ill_cycles = 0;
        last_fetch = 1'b0;
        repeat (5) begin
            @(posedge clk);
            check_idle();
        end
        rst <= 1'b0;
        @(posedge clk);
        check_idle();
        op <= window(0);
        while (ill_cycles < 20) begin
            @(posedge clk);
            cycles++;
            assert (cycles <= LIMIT) else stop_run("timeout, illegal stop never reached");
            assert (op_ok || fetched == 0) else stop_run("fetched nonzero while op_ok is low");
            assert (!last_fetch || fetched == 0)
                else stop_run("fetched nonzero in the wait cycle after a consume");
            assert (alu_wait == (fetch_q.size() != 0))
                else mismatch("fill wait", "alu_wait", fetch_q.size() != 0, alu_wait);
            check_pulse();
            if (illegal) begin
                assert (ptr == end_pos) else stop_run("illegal raised before the program end");
                assert (fetched == 0) else stop_run("fetched nonzero after the illegal opcode");
                ill_cycles++;
            end
            if (fetched != 0) begin
                if (fetch_q.size() == 0) begin
                    assert (ptr == model_ptr) else mismatch("stream", "pointer", model_ptr, ptr);
                    model_decode(flags);   // Flags of this decode cycle
                end
                want = fetch_q.pop_front();
                assert (fetched == want) else mismatch("stream", "fetched", want, fetched);
                ptr += fetched;
            end
            last_fetch = (fetched != 0);
            op    <= window(ptr);
            op_ok <= ($urandom % 4) != 0;  // Stall about a quarter of the time
            flags <= 8'($urandom);
        end
        assert (ev_q.size() == 0 && fetch_q.size() == 0) begin
            $display("Simulation passed");
        end else begin
            stop_run("expected events left after the illegal stop");
        end
        $finish;
    end

endmodule

// File: tlcs_ctrl.f
+incdir+.
ctrl_pkg.sv
operand_decode.sv
cond_eval.sv
ctrl_seq.sv
tlcs_ctrl.sv
tlcs_ctrl_tb.sv

// File: Bender.yml
package:
  name: tlcs_ctrl

sources:
  - ctrl_pkg.sv
  - operand_decode.sv
  - cond_eval.sv
  - ctrl_seq.sv
  - tlcs_ctrl.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tlcs_ctrl_tb.sv
